//--- list.f
+incdir+.
pim_data_pkg.sv
pim_ctrl_pkg.sv
pim_ctrl.sv
pim_crossbar_tile.sv
pim_psum_adder.sv
pim_macro_top.sv
pim_checker.sv
tb_pim_macro.sv

//--- pim_cfg.svh
// sizing macros for the processing-in-memory convolution macro
// include this wherever a width or a count of the crossbar is needed
// the packages take their type widths from here as well
`ifndef PIM_CFG_SVH
`define PIM_CFG_SVH

// input feature, split evenly over the row tiles
`define PIM_FEAT_W 64
`define PIM_TILE_ROWS 32 // rows in one crossbar tile
`define PIM_NUM_TILES 2 // feature width divided by tile rows

// weight columns stored in every tile, one is picked per compute
`define PIM_NUM_COLS 8
`define PIM_COL_AW 3 // log2 of the column count

// the ADC saturates at 31, so a full 32-row match reads as 31
`define PIM_ADC_W 5

// two clamped tile results summed, 62 at most
`define PIM_OUT_W 6

`endif

//--- pim_checker.sv
// scoreboard of the convolution macro testbench
// watches the command bus and the result port of the DUT, keeps its own
// copy of the tile weights and predicts every compute result
// samples on the falling edge, where both commands and results are stable
`timescale 1ns/10ps
`include "pim_cfg.svh"

module pim_checker (
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input pim_ctrl_pkg::pim_cmd_t cmd,
	input pim_data_pkg::psum_t file_exp, // expected sum that the stim line gives
	input pim_data_pkg::pim_result_t result,
	output int value_errors,
	output int timing_errors,
	output int pending // computes still waiting for their result
);
	import pim_ctrl_pkg::*;
	import pim_data_pkg::*;

	localparam int LATENCY = 3; // rising edges from accept to result.valid

	typedef struct packed {
		int due; // sample tick on which result.valid has to show
		logic [`PIM_COL_AW-1:0] col;
		psum_t model; // sum predicted from the weight copy
		psum_t file_val;
	} expect_t;

	weight_word_t shadow [`PIM_NUM_TILES][`PIM_NUM_COLS];
	expect_t exp_q[$];
	logic wr_pend; // write seen, lands in the tile on the following cycle
	logic wr_tile;
	logic [`PIM_COL_AW-1:0] wr_col;
	weight_word_t wr_data;
	int tick;

	// rows where both feature and weight are one, saturated at the ADC full scale
	function automatic adc_t tile_code(input weight_word_t w, input weight_word_t f);
		int cnt;
		cnt = 0;
		for (int r = 0; r < `PIM_TILE_ROWS; r++) begin
			if (w[r] && f[r])
				cnt++;
		end
		if (cnt > (1 << `PIM_ADC_W) - 1)
			cnt = (1 << `PIM_ADC_W) - 1; // a full 32-row match reads as 31
		return adc_t'(cnt);
	endfunction

	task automatic compare_result(input expect_t e);
		if (result.col !== e.col) begin
			value_errors++;
			$display("FAIL t=%0t result.col expected %0d actual %0d", $time, e.col, result.col);
		end
		if (result.value !== e.model) begin
			value_errors++;
			$display("FAIL t=%0t result.value expected %0d actual %0d",
				$time, e.model, result.value);
		end
		// the stim file carries its own expectation, held against the DUT as well
		if (result.value !== e.file_val) begin
			value_errors++;
			$display("FAIL t=%0t result.value (stim file) expected %0d actual %0d",
				$time, e.file_val, result.value);
		end
	endtask

	task automatic check_result();
		expect_t e;
		if (exp_q.size() != 0 && exp_q[0].due == tick) begin
			e = exp_q.pop_front();
			if (result.valid !== 1'b1) begin
				timing_errors++;
				$display("missing result.valid at %0t for the compute on column %0d",
					$time, e.col);
			end else begin
				compare_result(e);
			end
		end else if (result.valid !== 1'b0) begin
			timing_errors++; // nothing was due on this cycle
			$display("unexpected result.valid at %0t with no compute due", $time);
		end
	endtask

	task automatic take_command();
		expect_t e;
		if (cmd_valid && cmd.op == OP_WRITE) begin
			wr_pend = 1'b1;
			wr_tile = cmd.tile;
			wr_col = cmd.col;
			wr_data = cmd.payload[`PIM_TILE_ROWS-1:0]; // both tiles take the low word
		end else if (cmd_valid && cmd.op == OP_COMPUTE) begin
			e.due = tick + LATENCY;
			e.col = cmd.col;
			e.model = psum_t'(tile_code(shadow[0][cmd.col], cmd.payload[`PIM_TILE_ROWS-1:0]))
				+ psum_t'(tile_code(shadow[1][cmd.col],
				cmd.payload[`PIM_FEAT_W-1:`PIM_TILE_ROWS]));
			e.file_val = file_exp;
			exp_q.push_back(e);
		end
	endtask

	initial begin
		value_errors = 0;
		timing_errors = 0;
		pending = 0;
		tick = 0;
		wr_pend = 1'b0;
	end

	always @(negedge clk) begin
		// last cycle's write is in the array before this cycle's compute reads it
		if (wr_pend) begin
			shadow[wr_tile][wr_col] = wr_data;
			wr_pend = 1'b0;
		end
		if (!arst_n) begin
			for (int t = 0; t < `PIM_NUM_TILES; t++) begin
				for (int c = 0; c < `PIM_NUM_COLS; c++)
					shadow[t][c] = '0; // the tiles clear their weights in reset
			end
			exp_q.delete();
			if (result.valid !== 1'b0) begin
				timing_errors++;
				$display("result.valid was high during reset at %0t", $time);
			end
		end else begin
			check_result();
			take_command();
		end
		pending = exp_q.size();
		tick++;
	end

endmodule

//--- pim_crossbar_tile.sv
// one binary crossbar tile of the convolution macro
// stores the weight columns, and on a compute strobe counts the rows where
// both feature and the addressed column are one, then clamps like an ADC
// the clamped code is registered, so it shows one cycle after the strobe
`timescale 1ns/10ps
`include "pim_cfg.svh"

module pim_crossbar_tile (
	input logic clk,
	input logic arst_n,
	input logic we,
	input logic [`PIM_COL_AW-1:0] col,
	input pim_data_pkg::weight_word_t wdata,
	input logic compute,
	input pim_data_pkg::weight_word_t feature_slice,
	output pim_data_pkg::adc_t adc_out
);
	import pim_data_pkg::*;

	localparam int CNT_W = $clog2(`PIM_TILE_ROWS + 1); // popcount reaches the row count
	localparam int ADC_MAX = (1 << `PIM_ADC_W) - 1;

	weight_word_t weights [`PIM_NUM_COLS]; // one word per column of cells
	weight_word_t and_bits; // cells that conduct for this feature
	logic [CNT_W-1:0] ones;
	adc_t adc_next;

	// weight array starts out all zero so a fresh compute reads 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int c = 0; c < `PIM_NUM_COLS; c++)
				weights[c] <= '0;
		end else if (we) begin
			weights[col] <= wdata;
		end
	end

	assign and_bits = feature_slice & weights[col];

	// summing the column current is a plain count of the conducting cells
	always_comb begin
		ones = '0;
		for (int r = 0; r < `PIM_TILE_ROWS; r++)
			ones = ones + CNT_W'(and_bits[r]);
	end

	// the ADC cannot express a full match, it saturates one below
	assign adc_next = (ones > CNT_W'(ADC_MAX)) ? adc_t'(ADC_MAX) : adc_t'(ones);

	always_ff @(posedge clk) begin
		if (compute)
			adc_out <= adc_next; // holds between computes
	end

	// the control side never writes and reads a tile in the same cycle
	a_no_we_and_compute: assert property (@(posedge clk) disable iff (!arst_n)
		!(we && compute));

	// any access must land on a stored column
	a_col_range: assert property (@(posedge clk) disable iff (!arst_n)
		(we || compute) |-> (col < `PIM_NUM_COLS));

endmodule

//--- pim_ctrl.sv
// command decoder and result tracker of the convolution macro
// turns command strobes into registered tile writes and compute launches
// and carries valid and column alongside the tile pipeline to the adder
`timescale 1ns/10ps
`include "pim_cfg.svh"

module pim_ctrl (
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input pim_ctrl_pkg::pim_cmd_t cmd,
	output logic [`PIM_NUM_TILES-1:0] tile_we,
	output logic [`PIM_COL_AW-1:0] tile_col,
	output pim_data_pkg::weight_word_t tile_wdata,
	output logic compute,
	output pim_data_pkg::feature_t feature,
	output logic sum_valid,
	output logic [`PIM_COL_AW-1:0] sum_col
);
	import pim_ctrl_pkg::*;
	import pim_data_pkg::*;

	logic wr_hit; // accepted write in this cycle
	logic cmp_hit; // accepted compute in this cycle
	logic [1:0] valid_sr; // entry 0 is the compute strobe, entry 1 lines up with the ADC
	logic [`PIM_COL_AW-1:0] col_dly; // column of the compute now inside the tiles

	assign wr_hit = cmd_valid && (cmd.op == OP_WRITE);
	assign cmp_hit = cmd_valid && (cmd.op == OP_COMPUTE);

	// control half of the registered command stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tile_we <= '0;
			valid_sr <= '0;
		end else begin
			tile_we <= '0; // write strobes are single-cycle
			if (wr_hit)
				tile_we[cmd.tile] <= 1'b1;
			valid_sr <= {valid_sr[0], cmp_hit};
		end
	end

	// payload half, loaded only when a command is taken
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			tile_col <= cmd.col;
			tile_wdata <= weight_word_t'(cmd.payload[`PIM_TILE_ROWS-1:0]);
			feature <= cmd.payload;
		end
		col_dly <= tile_col; // follows the column one stage behind, like the ADC
	end

	assign compute = valid_sr[0];
	assign sum_valid = valid_sr[1];
	assign sum_col = col_dly;

	// a garbage op on the bus would silently turn into a nop here
	a_op_legal: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid |-> cmd.op inside {OP_NOP, OP_WRITE, OP_COMPUTE});

endmodule

//--- pim_ctrl_pkg.sv
// command types of the convolution macro
// the operation encoding and the command struct driven by the testbench
`include "pim_cfg.svh"

package pim_ctrl_pkg;

	// nop is all zeros so an idle bus decodes to nothing
	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_WRITE = 2'd1, // payload low word goes into one column of one tile
		OP_COMPUTE = 2'd2 // payload is the full feature for every tile
	} pim_op_e;

	// one command, taken in any cycle where cmd_valid is high
	typedef struct packed {
		pim_op_e op;
		logic tile; // tile picked by a write, ignored by a compute
		logic [`PIM_COL_AW-1:0] col;
		pim_data_pkg::feature_t payload;
	} pim_cmd_t;

endpackage

//--- pim_data_pkg.sv
// datapath types of the convolution macro
// features, stored weight columns, per-tile ADC codes and the final result
// widths come from the sizing macros, so include the config first
`include "pim_cfg.svh"

package pim_data_pkg;

	// whole binary feature as it arrives with a compute command
	typedef logic [`PIM_FEAT_W-1:0] feature_t;

	// one binary weight column of a tile, also the feature slice of a tile
	typedef logic [`PIM_TILE_ROWS-1:0] weight_word_t;

	typedef logic [`PIM_ADC_W-1:0] adc_t; // clamped popcount of one tile

	// sum over the tiles, wide enough that it never wraps
	typedef logic [`PIM_OUT_W-1:0] psum_t;

	// result handed back to the testbench, col tags which column was used
	typedef struct packed {
		logic valid;
		logic [`PIM_COL_AW-1:0] col;
		psum_t value;
	} pim_result_t;

endpackage

//--- pim_macro_top.sv
// top level of the processing-in-memory convolution macro
// takes command strobes, hands the feature halves to two row tiles and
// returns the summed result three register stages after a compute
`timescale 1ns/10ps
`include "pim_cfg.svh"

module pim_macro_top (
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input pim_ctrl_pkg::pim_cmd_t cmd,
	output pim_data_pkg::pim_result_t result
);
	import pim_data_pkg::*;

	logic [`PIM_NUM_TILES-1:0] tile_we;
	logic [`PIM_COL_AW-1:0] tile_col;
	weight_word_t tile_wdata;
	logic compute;
	feature_t feature;
	logic sum_valid;
	logic [`PIM_COL_AW-1:0] sum_col;
	adc_t adc0; // code of the low feature half
	adc_t adc1; // code of the high feature half

	pim_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd(cmd),
		.tile_we(tile_we), .tile_col(tile_col), .tile_wdata(tile_wdata),
		.compute(compute), .feature(feature),
		.sum_valid(sum_valid), .sum_col(sum_col)
	);

	// tile 0 sees rows 31:0 of the feature
	pim_crossbar_tile tile0 (
		.clk(clk), .arst_n(arst_n),
		.we(tile_we[0]), .col(tile_col), .wdata(tile_wdata),
		.compute(compute), .feature_slice(feature[`PIM_TILE_ROWS-1:0]),
		.adc_out(adc0)
	);

	// tile 1 sees rows 63:32
	pim_crossbar_tile tile1 (
		.clk(clk), .arst_n(arst_n),
		.we(tile_we[1]), .col(tile_col), .wdata(tile_wdata),
		.compute(compute), .feature_slice(feature[`PIM_FEAT_W-1:`PIM_TILE_ROWS]),
		.adc_out(adc1)
	);

	pim_psum_adder u_adder (
		.clk(clk), .arst_n(arst_n),
		.in_valid(sum_valid), .in_col(sum_col),
		.adc_a(adc0), .adc_b(adc1),
		.result(result)
	);

endmodule

//--- pim_psum_adder.sv
// partial-sum stage of the convolution macro
// adds the ADC codes of the two row tiles and registers the sum together
// with its valid and the column it was computed for
`timescale 1ns/10ps
`include "pim_cfg.svh"

module pim_psum_adder (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic [`PIM_COL_AW-1:0] in_col,
	input pim_data_pkg::adc_t adc_a,
	input pim_data_pkg::adc_t adc_b,
	output pim_data_pkg::pim_result_t result
);
	import pim_data_pkg::*;

	psum_t sum; // zero extended before adding, so 31 + 31 fits
	logic valid_q;
	logic [`PIM_COL_AW-1:0] col_q;
	psum_t value_q;

	assign sum = psum_t'(adc_a) + psum_t'(adc_b);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= in_valid; // one pulse per compute
	end

	// value and tag stay put while nothing is in flight
	always_ff @(posedge clk) begin
		if (in_valid) begin
			col_q <= in_col;
			value_q <= sum;
		end
	end

	assign result = '{valid: valid_q, col: col_q, value: value_q};

endmodule

//--- pim_stim.txt
# columns: op tile col payload expected_sum, all hex, one command per cycle
# op 0 idle, 1 write (low payload word into tile/col), 2 compute (payload is the feature)
0 0 0 0000000000000000 00
2 0 3 ffffffffffffffff 00
1 0 5 00000000ffffffff 00
1 1 5 00000000ffffffff 00
2 0 5 ffffffffffffffff 3e
2 0 5 00000000ffffffff 1f
0 0 0 0000000000000000 00
1 0 2 00000000ffff0000 00
2 0 2 00000000ffffffff 10
1 0 1 000000003a2cca3f 00
1 1 1 000000009e4d17b6 00
0 0 0 0000000000000000 00
2 0 1 c5f03a966d1e84f3 12
2 0 5 ffffffff00000000 1f
2 0 2 ffffffffffffffff 10
2 0 1 7e41a5c3d2b80f9c 13
2 0 0 ffffffffffffffff 00
0 0 0 0000000000000000 00
1 1 2 00000000f0f0f0f0 00
2 0 2 00000000ffffffff 10
2 0 2 0f0ff0f0ffffffff 18
2 0 5 00000000ffffffff 1f
0 0 0 0000000000000000 00
0 0 0 0000000000000000 00

//--- tb_pim_macro.sv
// testbench top of the processing-in-memory convolution macro
// reads command lines from pim_stim.txt, drives them into the DUT one per
// cycle and lets pim_checker compare every result against its prediction
// run from the project root with list.f, tb_pim_macro as the top
`timescale 1ns/10ps
`include "pim_cfg.svh"

module tb_pim_macro;
	import pim_ctrl_pkg::*;
	import pim_data_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 20; // room for the pipeline to empty after the last line

	typedef struct packed {
		logic [1:0] op;
		logic tile;
		logic [`PIM_COL_AW-1:0] col;
		feature_t payload;
		psum_t exp; // sum the line expects for a compute
	} stim_line_t;

	logic clk = 1'b0;
	logic arst_n;
	logic cmd_valid;
	pim_cmd_t cmd;
	psum_t file_exp;
	pim_result_t result;
	int value_errors;
	int timing_errors;
	int pending;
	stim_line_t lines[$];
	int n_lines;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	always #50 clk = ~clk; // 100 ns period

	pim_macro_top dut (
		.clk(clk), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd(cmd),
		.result(result)
	);

	pim_checker u_check (
		.clk(clk), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd(cmd), .file_exp(file_exp),
		.result(result),
		.value_errors(value_errors), .timing_errors(timing_errors), .pending(pending)
	);

	// count is -1 if the file cannot be opened
	task automatic read_stim(output int count);
		int fd;
		int n;
		string line;
		stim_line_t s;
		int op_v;
		int tile_v;
		int col_v;
		feature_t pl;
		int exp_v;
		count = 0;
		fd = $fopen("pim_stim.txt", "r");
		if (fd == 0) begin
			count = -1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n == 0 || line.len() == 0 || line.getc(0) == "#")
					continue; // blank or comment line
				n = $sscanf(line, "%h %h %h %h %h", op_v, tile_v, col_v, pl, exp_v);
				if (n != 5)
					continue;
				s.op = op_v[1:0];
				s.tile = tile_v[0];
				s.col = col_v[`PIM_COL_AW-1:0];
				s.payload = pl;
				s.exp = exp_v[`PIM_OUT_W-1:0];
				lines.push_back(s);
				count++;
			end
			$fclose(fd);
		end
	endtask

	// an idle line goes out as a nop with cmd_valid low
	task automatic drive_line(input stim_line_t s);
		cmd.op = pim_op_e'(s.op);
		cmd.tile = s.tile;
		cmd.col = s.col;
		cmd.payload = s.payload;
		file_exp = s.exp;
		cmd_valid = (s.op != 2'd0);
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, results still outstanding: %0d",
				cycle_cnt, pending);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		arst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		file_exp = '0;
		read_stim(n_lines);
		if (n_lines <= 0) begin
			$display("stimulus file pim_stim.txt could not be read or holds no commands");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			cycle_limit = RESET_CYCLES + n_lines + DRAIN_CYCLES;
			repeat (RESET_CYCLES) @(posedge clk);
			#1 arst_n = 1'b1;
			foreach (lines[i]) begin
				drive_line(lines[i]);
				@(posedge clk);
				#1;
			end
			cmd_valid = 1'b0;
			cmd = '0;
			while (pending != 0) begin
				@(posedge clk); // the checker empties its queue as results come
				#1;
			end
			repeat (3) @(posedge clk); // a stray valid would still be caught here
			$display("errors: %0d value, %0d timing", value_errors, timing_errors);
			if (value_errors == 0 && timing_errors == 0) begin
				$display("Simulation finished: PASS");
			end else begin
				$display("Simulation finished: FAIL");
			end
			$finish;
		end
	end

endmodule
